// ==== pmp_unit.f ====
+incdir+source
source/pmp_csr_pkg.sv
source/pmp_access_pkg.sv
source/pmp_apb_csr_port.sv
source/pmp_csr_file.sv
source/pmp_access_check.sv
source/pmp_unit.sv
bench/pmp_unit_tb.sv

// ==== bench/pmp_unit_tb.sv ====
`timescale 1ns/100ps

`include "pmp_config.svh"

module pmp_unit_tb
  import pmp_access_pkg::*;
();

  typedef enum logic [1:0] {
    STEP_WRITE = 2'd0,
    STEP_READ  = 2'd1,
    STEP_REQ   = 2'd2,
    STEP_RESET = 2'd3
  } step_kind_e;

  // One table row, data is the write data or the expected read data
  typedef struct packed {
    step_kind_e                 kind;
    logic [`PMP_APB_ADDR_W-1:0] addr;
    logic [31:0]                data;
    logic                       err;
    pmp_req_t                   req;
    pmp_resp_t                  resp;
  } step_t;

  logic                       clk;
  logic                       arst_n;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  logic [`PMP_APB_ADDR_W-1:0] paddr;
  logic [31:0]                pwdata;
  logic [31:0]                prdata;
  logic                       pready;
  logic                       pslverr;
  pmp_req_t                   req;
  pmp_resp_t                  resp;

  step_t steps[$];
  string names[$];
  int    data_errs   = 0;
  int    slverr_errs = 0;
  int    resp_errs   = 0;
  int    proto_errs  = 0;
  int    cycles      = 0;
  int    cycle_limit = 0;

  pmp_unit i_dut (
    .clk_i     (clk),
    .arst_n_i  (arst_n),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr),
    .req_i     (req),
    .resp_o    (resp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Run limit, four cycles per step plus reset
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if ((cycle_limit != 0) && (cycles >= cycle_limit)) begin
      $display("Timeout after %0d cycles, the step table did not complete", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  task automatic write_step(input string name, input logic [7:0] addr,
                            input logic [31:0] data, input logic err);
    step_t s;
    s      = '0;
    s.kind = STEP_WRITE;
    s.addr = addr;
    s.data = data;
    s.err  = err;
    steps.push_back(s);
    names.push_back(name);
  endtask

  task automatic read_step(input string name, input logic [7:0] addr,
                           input logic [31:0] data, input logic err);
    step_t s;
    s      = '0;
    s.kind = STEP_READ;
    s.addr = addr;
    s.data = data;
    s.err  = err;
    steps.push_back(s);
    names.push_back(name);
  endtask

  task automatic request_step(input string name, input logic [31:0] addr, input pmp_acc_e acc,
                              input pmp_priv_e priv, input logic allowed, input pmp_exc_e cause);
    step_t s;
    s              = '0;
    s.kind         = STEP_REQ;
    s.req.valid    = 1'b1;
    s.req.addr     = addr;
    s.req.acc      = acc;
    s.req.priv     = priv;
    s.resp.valid   = 1'b1;
    s.resp.allowed = allowed;
    s.resp.cause   = cause;
    steps.push_back(s);
    names.push_back(name);
  endtask

  task automatic reset_step(input string name);
    step_t s;
    s      = '0;
    s.kind = STEP_RESET;
    steps.push_back(s);
    names.push_back(name);
  endtask

  task automatic build_table();
    // Reset state
    read_step("rst_cfg", 8'h00, 32'h0, 1'b0);
    read_step("rst_addr0", 8'h10, 32'h0, 1'b0);
    read_step("rst_addr1", 8'h14, 32'h0, 1'b0);
    read_step("rst_addr2", 8'h18, 32'h0, 1'b0);
    read_step("rst_addr3", 8'h1C, 32'h0, 1'b0);
    read_step("rst_mseccfg", 8'h20, 32'h0, 1'b0);
    request_step("rst_u_exec", 32'h1000, EXEC, U, 1'b0, INSTR_ACC_FAULT);
    request_step("rst_u_read", 32'h1000, READ, U, 1'b0, LOAD_ACC_FAULT);
    request_step("rst_u_write", 32'h1000, WRITE, U, 1'b0, STORE_ACC_FAULT);
    request_step("rst_m_exec", 32'h1000, EXEC, M, 1'b1, NONE);
    request_step("rst_m_read", 32'h1000, READ, M, 1'b1, NONE);
    request_step("rst_m_write", 32'h1000, WRITE, M, 1'b1, NONE);
    // Entry 1 TOR 0x1000..0x1fff RX, entry 2 NA4 0x1800 R, entry 3 NA4 0x3000 RX
    write_step("prog_addr0", 8'h10, 32'h400, 1'b0);
    write_step("prog_addr1", 8'h14, 32'h800, 1'b0);
    write_step("prog_addr2", 8'h18, 32'h600, 1'b0);
    write_step("prog_addr3", 8'h1C, 32'hC00, 1'b0);
    write_step("prog_cfg", 8'h00, 32'h1511_0D00, 1'b0);
    read_step("prog_cfg_rd", 8'h00, 32'h1511_0D00, 1'b0);
    request_step("tor_low_read", 32'h1000, READ, U, 1'b1, NONE);
    request_step("tor_top_exec", 32'h1FFC, EXEC, U, 1'b1, NONE);
    request_step("tor_u_write", 32'h1004, WRITE, U, 1'b0, STORE_ACC_FAULT);
    request_step("tor_past_top", 32'h2000, READ, U, 1'b0, LOAD_ACC_FAULT);
    request_step("overlap_exec", 32'h1800, EXEC, U, 1'b1, NONE);
    request_step("na4_exec", 32'h3000, EXEC, U, 1'b1, NONE);
    request_step("na4_next_word", 32'h3004, READ, U, 1'b0, LOAD_ACC_FAULT);
    request_step("tor_m_write", 32'h1004, WRITE, M, 1'b1, NONE);
    // W without R on entry 1, reserved bits set on entry 3
    write_step("wr_reserved", 8'h00, 32'h7511_0A00, 1'b0);
    read_step("wr_reserved_rd", 8'h00, 32'h1511_0D00, 1'b0);
    // Lock entry 1 as TOR with R only
    write_step("lock1", 8'h00, 32'h1511_8900, 1'b0);
    read_step("lock1_rd", 8'h00, 32'h1511_8900, 1'b0);
    request_step("lock_m_write", 32'h1004, WRITE, M, 1'b0, STORE_ACC_FAULT);
    request_step("lock_m_read", 32'h1004, READ, M, 1'b1, NONE);
    write_step("lock_cfg_wr", 8'h00, 32'h1511_0F00, 1'b0);
    read_step("lock_cfg_rd", 8'h00, 32'h1511_8900, 1'b0);
    write_step("lock_addr1_wr", 8'h14, 32'hFFF, 1'b0);
    read_step("lock_addr1_rd", 8'h14, 32'h800, 1'b0);
    write_step("lock_addr0_wr", 8'h10, 32'h123, 1'b0);
    read_step("lock_addr0_rd", 8'h10, 32'h400, 1'b0);
    write_step("lock_rlb_wr", 8'h20, 32'h4, 1'b0);
    read_step("lock_rlb_rd", 8'h20, 32'h0, 1'b0);
    // RLB set before the lock
    reset_step("rlb_reset");
    read_step("rlb_cfg_clear", 8'h00, 32'h0, 1'b0);
    write_step("rlb_set", 8'h20, 32'h4, 1'b0);
    read_step("rlb_set_rd", 8'h20, 32'h4, 1'b0);
    write_step("rlb_lock1", 8'h00, 32'h0000_8900, 1'b0);
    read_step("rlb_lock1_rd", 8'h00, 32'h0000_8900, 1'b0);
    write_step("rlb_cfg_wr", 8'h00, 32'h0000_8B00, 1'b0);
    read_step("rlb_cfg_rd", 8'h00, 32'h0000_8B00, 1'b0);
    write_step("rlb_addr1_wr", 8'h14, 32'h900, 1'b0);
    read_step("rlb_addr1_rd", 8'h14, 32'h900, 1'b0);
    write_step("rlb_addr0_wr", 8'h10, 32'h200, 1'b0);
    read_step("rlb_addr0_rd", 8'h10, 32'h200, 1'b0);
    write_step("rlb_clear", 8'h20, 32'h0, 1'b0);
    read_step("rlb_clear_rd", 8'h20, 32'h0, 1'b0);
    write_step("relock_cfg_wr", 8'h00, 32'h0000_0900, 1'b0);
    read_step("relock_cfg_rd", 8'h00, 32'h0000_8B00, 1'b0);
    write_step("relock_addr1_wr", 8'h14, 32'h111, 1'b0);
    read_step("relock_addr1_rd", 8'h14, 32'h900, 1'b0);
    request_step("relock_m_write", 32'h1000, WRITE, M, 1'b1, NONE);
    request_step("relock_m_exec", 32'h1000, EXEC, M, 1'b0, INSTR_ACC_FAULT);
    request_step("relock_u_read", 32'h1000, READ, U, 1'b1, NONE);
    // Unmapped and misaligned offsets, checked against writable entries
    write_step("unmap_wr", 8'h28, 32'hFFFF_FFFF, 1'b1);
    read_step("unmap_rd", 8'h28, 32'h0, 1'b1);
    read_step("unmap_addr2_rd", 8'h18, 32'h0, 1'b0);
    write_step("misalign_wr", 8'h1D, 32'hABC, 1'b1);
    read_step("misalign_addr3", 8'h1C, 32'h0, 1'b0);
    read_step("misalign_rd", 8'h02, 32'h0, 1'b1);
    read_step("unmap_cfg_rd", 8'h00, 32'h0000_8B00, 1'b0);
  endtask

  task automatic rdata_check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      data_errs++;
      $display("Fail %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic slverr_check(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      slverr_errs++;
      $display("Fail %s: expected pslverr %b, actual %b", name, exp, act);
    end
  endtask

  task automatic resp_check(input string name, input pmp_resp_t exp, input pmp_resp_t act);
    if (act !== exp) begin
      resp_errs++;
      $display("Fail %s: expected valid %b allowed %b cause %0d, actual valid %b allowed %b cause %0d",
               name, exp.valid, exp.allowed, exp.cause, act.valid, act.allowed, act.cause);
    end
  endtask

  // Setup cycle, access cycle, then back to idle
  task automatic apb_transfer(input step_t s, input string name);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= (s.kind == STEP_WRITE);
    paddr   <= s.addr;
    pwdata  <= s.data;
    // Both stay low outside the access cycle
    @(negedge clk);
    if ((pready !== 1'b0) || (pslverr !== 1'b0)) begin
      proto_errs++;
      $display("Step %s: pready or pslverr was high in the setup cycle", name);
    end
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    if (pready !== 1'b1) begin
      proto_errs++;
      $display("Step %s: pready was not high in the access cycle", name);
    end
    slverr_check(name, s.err, pslverr);
    if (s.kind == STEP_READ) begin
      rdata_check(name, s.data, prdata);
    end
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  // Response is due one cycle after the request is driven
  task automatic send_request(input step_t s, input string name);
    @(posedge clk);
    req <= s.req;
    @(negedge clk);
    if (resp.valid !== 1'b0) begin
      proto_errs++;
      $display("Step %s: response valid was high before the request was sampled", name);
    end
    @(posedge clk);
    req.valid <= 1'b0;
    @(negedge clk);
    resp_check(name, s.resp, resp);
  endtask

  task automatic reset_pulse();
    @(posedge clk);
    arst_n <= 1'b0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
  endtask

  initial begin
    int total;
    build_table();
    cycle_limit = 4 * steps.size() + 10 + 2;
    arst_n  = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    req     = '0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    for (int i = 0; i < steps.size(); i++) begin
      case (steps[i].kind)
        STEP_WRITE, STEP_READ: apb_transfer(steps[i], names[i]);
        STEP_REQ:              send_request(steps[i], names[i]);
        default:               reset_pulse();
      endcase
    end
    @(posedge clk);
    total = data_errs + slverr_errs + resp_errs + proto_errs;
    $display("Errors: read data %0d, slave error %0d, response %0d, protocol %0d",
             data_errs, slverr_errs, resp_errs, proto_errs);
    if (total == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== source/pmp_unit.sv ====
`timescale 1ns/100ps

`include "pmp_config.svh"

module pmp_unit
  import pmp_csr_pkg::*;
  import pmp_access_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       psel_i,
  input  logic                       penable_i,
  input  logic                       pwrite_i,
  input  logic [`PMP_APB_ADDR_W-1:0] paddr_i,
  input  logic [31:0]                pwdata_i,
  output logic [31:0]                prdata_o,
  output logic                       pready_o,
  output logic                       pslverr_o,
  input  pmp_req_t                   req_i,
  output pmp_resp_t                  resp_o
);

  pmp_csr_wr_t    csr_wr;
  pmp_csr_state_t csr_state;

  // APB register access
  pmp_apb_csr_port i_apb_csr_port (
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .csr_state_i (csr_state),
    .csr_wr_o    (csr_wr)
  );

  pmp_csr_file i_csr_file (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .csr_wr_i    (csr_wr),
    .csr_state_o (csr_state)
  );

  // Request checker with one cycle latency
  pmp_access_check i_access_check (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .csr_state_i (csr_state),
    .req_i       (req_i),
    .resp_o      (resp_o)
  );

endmodule

// ==== source/pmp_access_check.sv ====
`timescale 1ns/100ps

`include "pmp_config.svh"

module pmp_access_check
  import pmp_csr_pkg::*;
  import pmp_access_pkg::*;
(
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  pmp_csr_state_t csr_state_i,
  input  pmp_req_t       req_i,
  output pmp_resp_t      resp_o
);

  logic [31:0]                 req_word;
  logic [`PMP_NUM_REGIONS-1:0] region_match;
  logic                        hit;
  pmp_cfg_t                    hit_cfg;
  logic                        perm;
  logic                        allowed;
  pmp_exc_e                    cause;
  logic                        resp_valid_q;
  logic                        resp_allowed_q;
  pmp_exc_e                    resp_cause_q;

  // Word address, same scale as pmpaddr bits 33:2
  assign req_word = {2'b00, req_i.addr[31:2]};

  always_comb begin
    logic [31:0] prev_addr;
    logic [31:0] napot_mask;
    prev_addr = '0;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      // Trailing ones plus the first zero are don't care bits
      napot_mask = csr_state_i.addr[i] ^ (csr_state_i.addr[i] + 32'd1);
      case (csr_state_i.cfg[i].mode)
        TOR:     region_match[i] = (req_word >= prev_addr) &&
                                   (req_word < csr_state_i.addr[i]);
        NA4:     region_match[i] = (req_word == csr_state_i.addr[i]);
        NAPOT:   region_match[i] = ((req_word & ~napot_mask) ==
                                    (csr_state_i.addr[i] & ~napot_mask));
        default: region_match[i] = 1'b0;
      endcase
      prev_addr = csr_state_i.addr[i];
    end
  end

  // Lowest index wins, so scan downwards
  always_comb begin
    hit     = 1'b0;
    hit_cfg = '0;
    for (int i = `PMP_NUM_REGIONS - 1; i >= 0; i--) begin
      if (region_match[i]) begin
        hit     = 1'b1;
        hit_cfg = csr_state_i.cfg[i];
      end
    end
  end

  always_comb begin
    case (req_i.acc)
      EXEC:    perm = hit_cfg.exec;
      READ:    perm = hit_cfg.read;
      default: perm = hit_cfg.write;
    endcase
    if (!hit) begin
      allowed = (req_i.priv == M);
    end else if (req_i.priv == M) begin
      allowed = ~hit_cfg.lock | perm;
    end else begin
      allowed = perm;
    end
    case (req_i.acc)
      EXEC:    cause = INSTR_ACC_FAULT;
      READ:    cause = LOAD_ACC_FAULT;
      default: cause = STORE_ACC_FAULT;
    endcase
    if (allowed) begin
      cause = NONE;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    resp_allowed_q <= allowed;
    resp_cause_q   <= cause;
  end

  assign resp_o.valid   = resp_valid_q;
  assign resp_o.allowed = resp_allowed_q;
  assign resp_o.cause   = resp_cause_q;

endmodule

// ==== source/pmp_csr_file.sv ====
`timescale 1ns/100ps

`include "pmp_config.svh"

module pmp_csr_file
  import pmp_csr_pkg::*;
(
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  pmp_csr_wr_t    csr_wr_i,
  output pmp_csr_state_t csr_state_o
);

  pmp_cfg_arr_t  cfg_q;
  pmp_cfg_arr_t  cfg_d;
  pmp_addr_arr_t addr_q;
  pmp_addr_arr_t addr_d;
  logic          rlb_q;
  logic          rlb_d;

  logic [`PMP_NUM_REGIONS-1:0] locked;
  logic [`PMP_NUM_REGIONS-1:0] addr_wr_ok;
  logic                        any_lock;

  // Legal value of one cfg byte after a write attempt
  function automatic pmp_cfg_t legalize_cfg(pmp_cfg_t cur, pmp_cfg_t wr, logic rlb);
    pmp_cfg_t res;
    res = wr;
    // W without R is reserved, RWX stays as it was
    if (wr.write && !wr.read) begin
      res.exec  = cur.exec;
      res.write = cur.write;
      res.read  = cur.read;
    end
    if (cur.lock && !rlb) begin
      res = cur;
    end
    res.zero = 2'b00;
    return res;
  endfunction

  // Lock is only effective while RLB is clear
  always_comb begin
    any_lock = 1'b0;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      locked[i] = cfg_q[i].lock & ~rlb_q;
      any_lock  = any_lock | cfg_q[i].lock;
    end
  end

  // pmpaddr i is frozen by its own lock or by a locked TOR entry above it
  always_comb begin
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      addr_wr_ok[i] = ~locked[i];
      if (i < `PMP_NUM_REGIONS - 1) begin
        if (locked[i+1] && (cfg_q[i+1].mode == TOR)) begin
          addr_wr_ok[i] = 1'b0;
        end
      end
    end
  end

  always_comb begin
    cfg_d  = cfg_q;
    addr_d = addr_q;
    rlb_d  = rlb_q;
    if (csr_wr_i.valid) begin
      case (csr_wr_i.sel)
        CFG: begin
          for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
            cfg_d[i] = legalize_cfg(cfg_q[i], pmp_cfg_t'(csr_wr_i.data[8*i +: 8]), rlb_q);
          end
        end
        ADDR: begin
          if (addr_wr_ok[csr_wr_i.idx]) begin
            addr_d[csr_wr_i.idx] = csr_wr_i.data;
          end
        end
        MSECCFG: begin
          // RLB is sticky once any entry is locked
          if (rlb_q || !any_lock) begin
            rlb_d = csr_wr_i.data[2];
          end
        end
        default: rlb_d = rlb_q;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_q  <= '0;
      addr_q <= '0;
      rlb_q  <= 1'b0;
    end else begin
      cfg_q  <= cfg_d;
      addr_q <= addr_d;
      rlb_q  <= rlb_d;
    end
  end

  assign csr_state_o.cfg  = cfg_q;
  assign csr_state_o.addr = addr_q;
  assign csr_state_o.rlb  = rlb_q;

endmodule

// ==== source/pmp_apb_csr_port.sv ====
`timescale 1ns/100ps

`include "pmp_config.svh"

module pmp_apb_csr_port
  import pmp_csr_pkg::*;
(
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [`PMP_APB_ADDR_W-1:0]   paddr_i,
  input  logic [31:0]                  pwdata_i,
  output logic [31:0]                  prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  input  pmp_csr_state_t               csr_state_i,
  output pmp_csr_wr_t                  csr_wr_o
);

  logic                       access;
  logic                       mapped;
  pmp_csr_sel_e               sel;
  logic [1:0]                 idx;
  logic [`PMP_APB_ADDR_W-1:0] addr_ofs;

  // No wait states, every access cycle completes
  assign access    = psel_i & penable_i;
  assign pready_o  = access;
  assign pslverr_o = access & ~mapped;

  // Offset relative to pmpaddr0
  assign addr_ofs = paddr_i - `PMP_OFS_ADDR_BASE;

  // Register decode, misaligned offsets are unmapped
  always_comb begin
    mapped = 1'b0;
    sel    = CFG;
    idx    = 2'd0;
    if (paddr_i[1:0] == 2'b00) begin
      if (paddr_i == `PMP_OFS_CFG) begin
        mapped = 1'b1;
        sel    = CFG;
      end else if ((paddr_i >= `PMP_OFS_ADDR_BASE) &&
                   (paddr_i < (`PMP_OFS_ADDR_BASE + 4 * `PMP_NUM_REGIONS))) begin
        mapped = 1'b1;
        sel    = ADDR;
        idx    = addr_ofs[3:2];
      end else if (paddr_i == `PMP_OFS_MSECCFG) begin
        mapped = 1'b1;
        sel    = MSECCFG;
      end
    end
  end

  // Read data, unmapped reads return zero
  always_comb begin
    prdata_o = '0;
    if (mapped) begin
      case (sel)
        CFG:     prdata_o = csr_state_i.cfg;
        ADDR:    prdata_o = csr_state_i.addr[idx];
        MSECCFG: prdata_o[2] = csr_state_i.rlb;
        default: prdata_o = '0;
      endcase
    end
  end

  // Write request lasts for the single access cycle
  always_comb begin
    csr_wr_o.valid = access & pwrite_i & mapped;
    csr_wr_o.sel   = sel;
    csr_wr_o.idx   = idx;
    csr_wr_o.data  = pwdata_i;
  end

endmodule

// ==== source/pmp_access_pkg.sv ====
package pmp_access_pkg;

  typedef enum logic [1:0] {
    EXEC  = 2'd0,
    READ  = 2'd1,
    WRITE = 2'd2
  } pmp_acc_e;

  // Privilege encodings as in mstatus.MPP
  typedef enum logic [1:0] {
    U = 2'd0,
    M = 2'd3
  } pmp_priv_e;

  // Exception cause codes
  typedef enum logic [5:0] {
    NONE            = 6'd0,
    INSTR_ACC_FAULT = 6'd1,
    LOAD_ACC_FAULT  = 6'd5,
    STORE_ACC_FAULT = 6'd7
  } pmp_exc_e;

  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    pmp_acc_e    acc;
    pmp_priv_e   priv;
  } pmp_req_t;

  typedef struct packed {
    logic     valid;
    logic     allowed;
    pmp_exc_e cause;
  } pmp_resp_t;

endpackage

// ==== source/pmp_csr_pkg.sv ====
package pmp_csr_pkg;

  // Address matching mode of one region
  typedef enum logic [1:0] {
    OFF   = 2'd0,
    TOR   = 2'd1,
    NA4   = 2'd2,
    NAPOT = 2'd3
  } pmp_mode_e;

  // One region config byte, standard bit order
  typedef struct packed {
    logic      lock;
    logic [1:0] zero;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  // Four cfg bytes form one pmpcfg word
  typedef pmp_cfg_t [3:0] pmp_cfg_arr_t;

  // Address bits 33:2 of each region
  typedef logic [3:0][31:0] pmp_addr_arr_t;

  typedef enum logic [1:0] {
    CFG     = 2'd0,
    ADDR    = 2'd1,
    MSECCFG = 2'd2
  } pmp_csr_sel_e;

  typedef struct packed {
    logic         valid;
    pmp_csr_sel_e sel;
    logic [1:0]   idx;
    logic [31:0]  data;
  } pmp_csr_wr_t;

  typedef struct packed {
    pmp_cfg_arr_t  cfg;
    pmp_addr_arr_t addr;
    logic          rlb;
  } pmp_csr_state_t;

endpackage

// ==== source/pmp_config.svh ====
`ifndef PMP_CONFIG_SVH
`define PMP_CONFIG_SVH

// Number of protection regions, one pmpcfg word holds all of them
`define PMP_NUM_REGIONS 4

// APB byte address width
`define PMP_APB_ADDR_W 8

// Packed pmpcfg word, entry 0 in the low byte
`define PMP_OFS_CFG 8'h00

// pmpaddr0, next entries follow at 4 byte steps
`define PMP_OFS_ADDR_BASE 8'h10

// mseccfg, only RLB is kept
`define PMP_OFS_MSECCFG 8'h20

`endif
